// File: hw/uart_cmd_pkg.sv
package uart_cmd_pkg;

  // ##########################################################
  // Serial timing
  // ##########################################################

  localparam int BAUD_DIV        = 8;   // Clock cycles per serial bit
  localparam int GAP_BITS        = 2;   // Idle bit periods between frames
  localparam int RX_TIMEOUT_BITS = 40;  // Bit periods to wait for a response start edge
  localparam int FRAME_BITS      = 11;  // Start, 8 data, parity, stop

  localparam int GAP_CYCLES    = GAP_BITS * BAUD_DIV;
  localparam int RX_TMO_CYCLES = RX_TIMEOUT_BITS * BAUD_DIV;

  // Counter widths derived from the timing above
  localparam int BAUD_CNT_W = $clog2(BAUD_DIV);
  localparam int BIT_CNT_W  = $clog2(FRAME_BITS);
  localparam int GAP_CNT_W  = $clog2(GAP_CYCLES);
  localparam int TMO_CNT_W  = $clog2(RX_TMO_CYCLES);

  // ##########################################################
  // Command format
  // ##########################################################

  localparam int CMD_W      = 16;
  localparam int CMD_RW_BIT = 15;  // 1 for write, 0 for read

  // ##########################################################
  // APB register map and STATUS layout
  // ##########################################################

  localparam logic [7:0] ADDR_CMD    = 8'h00;
  localparam logic [7:0] ADDR_STATUS = 8'h04;
  localparam logic [7:0] ADDR_RDATA  = 8'h08;

  localparam int ST_BUSY    = 0;
  localparam int ST_DONE    = 1;
  localparam int ST_PERR    = 2;
  localparam int ST_TIMEOUT = 3;

endpackage

// File: hw/uart_rx_if.sv
`timescale 1ns/1ps

interface uart_rx_if;

  logic       arm;        // One-cycle request to listen for a frame
  logic       valid;      // One-cycle result strobe
  logic [7:0] data;
  logic       par_err;
  logic       timed_out;  // No start edge seen before the timeout

  modport seq (
    output arm,
    input  valid,
    input  data,
    input  par_err,
    input  timed_out
  );

  modport link (
    input  arm,
    output valid,
    output data,
    output par_err,
    output timed_out
  );

endinterface

// File: hw/uart_tx_frame.sv
`timescale 1ns/1ps

module uart_tx_frame
  import uart_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       valid,
  input  logic [7:0] data,
  output logic       ready,
  output logic       tx
);

  logic                  active;
  logic [BAUD_CNT_W-1:0] baud_cnt;
  logic [BIT_CNT_W-1:0]  bit_cnt;
  logic [FRAME_BITS-2:0] shreg;     // Bits still to go out after the one on tx
  logic                  bit_end;
  logic                  accept;

  assign ready   = !active;
  assign accept  = valid && !active;
  assign bit_end = (baud_cnt == BAUD_CNT_W'(BAUD_DIV - 1));

  // ##########################################################
  // Bit timing and line driver
  // ##########################################################

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      active   <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      tx       <= 1'b1;
    end
    else if (accept)
    begin
      active   <= 1'b1;
      tx       <= 1'b0;  // Start bit
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end
    else if (active)
    begin
      if (bit_end)
      begin
        baud_cnt <= '0;
        if (bit_cnt == BIT_CNT_W'(FRAME_BITS - 1))
          active <= 1'b0;  // Stop bit done, line already high
        else
        begin
          tx      <= shreg[0];
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
      else
        baud_cnt <= baud_cnt + 1'b1;
    end
  end

  // Stop, odd parity, then data LSB first
  always_ff @(posedge clk)
  begin
    if (accept)
      shreg <= {1'b1, ~^data, data};
    else if (active && bit_end)
      shreg <= {1'b1, shreg[FRAME_BITS-2:1]};
  end

endmodule

// File: hw/uart_rx_frame.sv
`timescale 1ns/1ps

module uart_rx_frame
  import uart_cmd_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   rx,
  uart_rx_if.link link
);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_WAIT,
    RX_START,
    RX_BITS
  } rx_state_t;

  rx_state_t             state;
  logic                  rx_meta;
  logic                  rx_sync;
  logic                  rx_prev;
  logic                  fall;
  logic [BAUD_CNT_W-1:0] baud_cnt;
  logic [BIT_CNT_W-1:0]  bit_cnt;
  logic [TMO_CNT_W-1:0]  tmo_cnt;
  logic [FRAME_BITS-3:0] shreg;     // Parity in the top bit, data below
  logic                  bit_end;
  logic                  stop_bit;

  assign fall     = rx_prev && !rx_sync;
  assign bit_end  = (baud_cnt == BAUD_CNT_W'(BAUD_DIV - 1));
  assign stop_bit = (bit_cnt == BIT_CNT_W'(FRAME_BITS - 2));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  // ##########################################################
  // Frame receiver
  // ##########################################################

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state          <= RX_IDLE;
      baud_cnt       <= '0;
      bit_cnt        <= '0;
      tmo_cnt        <= '0;
      link.valid     <= 1'b0;
      link.data      <= '0;
      link.par_err   <= 1'b0;
      link.timed_out <= 1'b0;
    end
    else
    begin
      link.valid <= 1'b0;
      case (state)
        RX_IDLE:
        begin
          tmo_cnt <= '0;
          if (link.arm)
            state <= RX_WAIT;
        end
        RX_WAIT:
        begin
          if (fall)
          begin
            state    <= RX_START;
            baud_cnt <= '0;
          end
          else if (tmo_cnt == TMO_CNT_W'(RX_TMO_CYCLES - 2))
          begin
            state          <= RX_IDLE;  // Silent peer
            link.valid     <= 1'b1;
            link.data      <= '0;
            link.par_err   <= 1'b0;
            link.timed_out <= 1'b1;
          end
          else
            tmo_cnt <= tmo_cnt + 1'b1;
        end
        RX_START:
        begin
          // Check the line again half a bit into the start bit
          if (baud_cnt == BAUD_CNT_W'(BAUD_DIV / 2 - 1))
          begin
            baud_cnt <= '0;
            bit_cnt  <= '0;
            state    <= rx_sync ? RX_WAIT : RX_BITS;  // High again means a glitch
          end
          else
            baud_cnt <= baud_cnt + 1'b1;
        end
        RX_BITS:
        begin
          if (bit_end)
          begin
            baud_cnt <= '0;
            if (stop_bit)
            begin
              state          <= RX_IDLE;
              link.valid     <= 1'b1;
              link.data      <= shreg[7:0];
              link.par_err   <= shreg[8] != ~^shreg[7:0];
              link.timed_out <= 1'b0;
            end
            else
              bit_cnt <= bit_cnt + 1'b1;
          end
          else
            baud_cnt <= baud_cnt + 1'b1;
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == RX_BITS && bit_end && !stop_bit)
      shreg <= {rx_sync, shreg[FRAME_BITS-3:1]};  // LSB arrives first
  end

endmodule

// File: hw/uart_cmd_seq.sv
`timescale 1ns/1ps

module uart_cmd_seq
  import uart_cmd_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic             start,
  input  logic [CMD_W-1:0] cmd,
  input  logic             tx_ready,
  output logic             busy,
  output logic             done,
  output logic             perr,
  output logic             timeout,
  output logic [7:0]       rdata,
  output logic             tx_valid,
  output logic [7:0]       tx_data,
  uart_rx_if.seq           rx
);

  typedef enum logic [3:0] {
    S_IDLE,
    S_LO_SEND,
    S_LO_WAIT,
    S_GAP1,
    S_HI_SEND,
    S_HI_WAIT,
    S_GAP2,
    S_ARM,
    S_RESP
  } seq_state_t;

  seq_state_t           state;
  logic [CMD_W-1:0]     cmd_q;
  logic [GAP_CNT_W-1:0] gap_cnt;
  logic                 gap_end;

  assign busy     = (state != S_IDLE);
  assign tx_valid = (state == S_LO_SEND) || (state == S_HI_SEND);
  assign tx_data  = (state == S_HI_SEND) ? cmd_q[15:8] : cmd_q[7:0];
  assign rx.arm   = (state == S_ARM);
  assign gap_end  = (gap_cnt == GAP_CNT_W'(GAP_CYCLES - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= S_IDLE;
      gap_cnt <= '0;
      done    <= 1'b0;
      perr    <= 1'b0;
      timeout <= 1'b0;
    end
    else
    begin
      done <= 1'b0;
      case (state)
        S_IDLE:    if (start) state <= S_LO_SEND;
        S_LO_SEND: if (tx_ready) state <= S_LO_WAIT;  // Byte accepted this cycle
        S_LO_WAIT:
        begin
          gap_cnt <= '0;
          if (tx_ready)
            state <= S_GAP1;
        end
        S_GAP1:
        begin
          gap_cnt <= gap_cnt + 1'b1;
          if (gap_end)
            state <= S_HI_SEND;
        end
        S_HI_SEND: if (tx_ready) state <= S_HI_WAIT;
        S_HI_WAIT:
        begin
          gap_cnt <= '0;
          if (tx_ready && cmd_q[CMD_RW_BIT])
          begin
            state   <= S_IDLE;
            done    <= 1'b1;
            perr    <= 1'b0;
            timeout <= 1'b0;
          end
          else if (tx_ready)
            state <= S_GAP2;
        end
        S_GAP2:
        begin
          gap_cnt <= gap_cnt + 1'b1;
          if (gap_end)
            state <= S_ARM;
        end
        S_ARM: state <= S_RESP;
        S_RESP:
        begin
          if (rx.valid)
          begin
            state   <= S_IDLE;
            done    <= 1'b1;
            perr    <= rx.par_err;
            timeout <= rx.timed_out;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == S_IDLE && start)
      cmd_q <= cmd;
    if (state == S_RESP && rx.valid)
      rdata <= rx.data;
  end

endmodule

// File: hw/uart_cmd_apb.sv
`timescale 1ns/1ps

module uart_cmd_apb
  import uart_cmd_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic [7:0]       paddr,
  input  logic             psel,
  input  logic             penable,
  input  logic             pwrite,
  input  logic [31:0]      pwdata,
  input  logic             busy,
  input  logic             done,
  input  logic             perr,
  input  logic             timeout,
  input  logic [7:0]       rdata,
  output logic [31:0]      prdata,
  output logic             pready,
  output logic             pslverr,
  output logic             start,
  output logic [CMD_W-1:0] cmd
);

  logic       access;
  logic       cmd_wr;
  logic       in_flight;
  logic       done_q;
  logic       perr_q;
  logic       tmo_q;
  logic [7:0] rdata_q;
  logic [3:0] status;

  assign pready    = 1'b1;
  assign access    = psel && penable;
  assign in_flight = busy || start;  // Covers the cycle before the sequencer leaves idle
  assign cmd_wr    = access && pwrite && (paddr == ADDR_CMD);
  assign pslverr   = cmd_wr && in_flight;

  always_comb
  begin
    status              = '0;
    status[ST_BUSY]     = in_flight;
    status[ST_DONE]     = done_q;
    status[ST_PERR]     = perr_q;
    status[ST_TIMEOUT]  = tmo_q;
  end

  always_comb
  begin
    case (paddr)
      ADDR_CMD:    prdata = {{(32 - CMD_W){1'b0}}, cmd};
      ADDR_STATUS: prdata = {28'd0, status};
      ADDR_RDATA:  prdata = {24'd0, rdata_q};
      default:     prdata = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      start   <= 1'b0;
      cmd     <= '0;
      done_q  <= 1'b0;
      perr_q  <= 1'b0;
      tmo_q   <= 1'b0;
      rdata_q <= '0;
    end
    else
    begin
      start <= 1'b0;
      if (done)
      begin
        done_q <= 1'b1;
        perr_q <= perr;
        tmo_q  <= timeout;
        if (!cmd[CMD_RW_BIT])
          rdata_q <= rdata;  // Only reads bring back a byte
      end
      // A new command wins over a result landing in the same cycle
      if (cmd_wr && !in_flight)
      begin
        start  <= 1'b1;
        cmd    <= pwdata[CMD_W-1:0];
        done_q <= 1'b0;
        perr_q <= 1'b0;
        tmo_q  <= 1'b0;
      end
    end
  end

endmodule

// File: hw/uart_cmd_top.sv
`timescale 1ns/1ps

module uart_cmd_top
  import uart_cmd_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic [7:0]  paddr,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  output logic        tx,
  input  logic        rx
);

  logic             start;
  logic [CMD_W-1:0] cmd;
  logic             busy;
  logic             done;
  logic             perr;
  logic             timeout;
  logic [7:0]       rdata;
  logic             tx_valid;
  logic             tx_ready;
  logic [7:0]       tx_data;

  uart_rx_if rx_link ();

  uart_cmd_apb u_apb (
    .clk     (clk),
    .rst_n   (rst_n),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .busy    (busy),
    .done    (done),
    .perr    (perr),
    .timeout (timeout),
    .rdata   (rdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .start   (start),
    .cmd     (cmd)
  );

  uart_cmd_seq u_seq (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start),
    .cmd      (cmd),
    .tx_ready (tx_ready),
    .busy     (busy),
    .done     (done),
    .perr     (perr),
    .timeout  (timeout),
    .rdata    (rdata),
    .tx_valid (tx_valid),
    .tx_data  (tx_data),
    .rx       (rx_link.seq)
  );

  uart_tx_frame u_tx (
    .clk   (clk),
    .rst_n (rst_n),
    .valid (tx_valid),
    .data  (tx_data),
    .ready (tx_ready),
    .tx    (tx)
  );

  uart_rx_frame u_rx (
    .clk   (clk),
    .rst_n (rst_n),
    .rx    (rx),
    .link  (rx_link.link)
  );

endmodule

// File: dv/uart_cmd_assert.sv
`timescale 1ns/1ps

module uart_cmd_assert (
  input logic clk,
  input logic rst_n,
  input logic psel,
  input logic penable,
  input logic pslverr,
  input logic busy,
  input logic done,
  input logic start,
  input logic tx
);

  // Only the sequencer may pull the line low
  tx_idle_when_free: assert property (
    @(posedge clk) disable iff (!rst_n) !busy |-> tx
  ) else $error("tx is low while no command is in flight");

  // A refused command leaves the transaction in flight running until its done
  slverr_in_access: assert property (
    @(posedge clk) disable iff (!rst_n) pslverr |-> (psel && penable) ##1 (busy || done)
  ) else $error("pslverr raised outside an access phase or with no command in flight");

  no_done_with_start: assert property (
    @(posedge clk) disable iff (!rst_n) !(done && start)
  ) else $error("done and start are high in the same cycle");

endmodule

bind uart_cmd_top uart_cmd_assert u_assert (
  .clk     (clk),
  .rst_n   (rst_n),
  .psel    (psel),
  .penable (penable),
  .pslverr (pslverr),
  .busy    (busy),
  .done    (done),
  .start   (start),
  .tx      (tx)
);

// File: dv/uart_cmd_tb.sv
`timescale 1ns/1ps

module uart_cmd_tb
  import uart_cmd_pkg::*;
();

  logic        clk;
  logic        rst_n;
  logic [7:0]  paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        tx;
  logic        rx;

  integer       value_errs;
  integer       other_errs;
  integer       seed;
  integer       cycle_cnt;
  integer       fd;
  integer       n_cases;
  integer       fault;
  string        line;
  logic [127:0] name;
  logic [15:0]  cmd;
  logic [7:0]   resp;
  logic [7:0]   exp_rd;

  uart_cmd_top dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .tx      (tx),
    .rx      (rx)
  );

  always #4 clk = ~clk;

  always @(posedge clk)
    cycle_cnt <= cycle_cnt + 1;

  task automatic report_mismatch(input logic [127:0] tname, input string what,
                                 input logic [31:0] exp, input logic [31:0] got);
    $display("[FAIL] %0s %0s expected 0x%0h actual 0x%0h", tname, what, exp, got);
    value_errs = value_errs + 1;
  endtask

  // ##########################################################
  // APB master
  // ##########################################################

  task automatic apb_write(input logic [127:0] tname, input logic [7:0] addr,
                           input logic [31:0] data, output logic err);
    @(negedge clk);
    paddr  = addr;
    pwdata = data;
    pwrite = 1'b1;
    psel   = 1'b1;
    @(negedge clk);
    penable = 1'b1;
    #1;
    err = pslverr;  // Combinational in the access phase
    if (pready !== 1'b1)
      report_mismatch(tname, "pready on write", 32'd1, {31'd0, pready});
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_read(input logic [127:0] tname, input logic [7:0] addr,
                          output logic [31:0] data);
    @(negedge clk);
    paddr  = addr;
    pwrite = 1'b0;
    psel   = 1'b1;
    @(negedge clk);
    penable = 1'b1;
    #1;
    data = prdata;
    if (pready !== 1'b1)
      report_mismatch(tname, "pready on read", 32'd1, {31'd0, pready});
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // ##########################################################
  // Serial peer
  // ##########################################################

  // Returns at the middle of the stop bit and counts in idle the falling edges spent waiting
  task automatic recv_frame(input logic [127:0] tname, output logic [7:0] data,
                            output integer idle);
    logic [9:0] bits;
    logic       seen;
    integer     i;
    data = '0;
    idle = 0;
    seen = 1'b0;
    while (!seen && idle < 4 * FRAME_BITS * BAUD_DIV)
    begin
      @(negedge clk);
      idle = idle + 1;
      seen = (tx == 1'b0);
    end
    if (!seen)
    begin
      $display("Case %0s: no start bit appeared on tx in time", tname);
      other_errs = other_errs + 1;
      return;
    end
    repeat (BAUD_DIV / 2 - 1) @(negedge clk);
    if (tx !== 1'b0)
    begin
      $display("Case %0s: start bit on tx did not last to mid-bit", tname);
      other_errs = other_errs + 1;
    end
    for (i = 0; i < FRAME_BITS - 1; i++)
    begin
      repeat (BAUD_DIV) @(negedge clk);
      bits[i] = tx;
    end
    data = bits[7:0];
    if (bits[8] !== ~^bits[7:0])
      report_mismatch(tname, "tx parity", {31'd0, ~^bits[7:0]}, {31'd0, bits[8]});
    if (bits[9] !== 1'b1)
      report_mismatch(tname, "tx stop bit", 32'd1, {31'd0, bits[9]});
  endtask

  task automatic send_frame(input logic [7:0] data, input logic flip);
    logic [FRAME_BITS-1:0] bits;
    integer                i;
    bits = {1'b1, (~^data) ^ flip, data, 1'b0};
    for (i = 0; i < FRAME_BITS; i++)
    begin
      @(negedge clk);
      rx = bits[i];
      repeat (BAUD_DIV - 1) @(negedge clk);
    end
  endtask

  task automatic run_peer(input logic [127:0] tname, input logic [15:0] tcmd,
                          input logic [7:0] tresp, input integer tfault);
    logic [7:0] lo;
    logic [7:0] hi;
    integer     idle;
    integer     extra;
    recv_frame(tname, lo, idle);
    if (lo !== tcmd[7:0])
      report_mismatch(tname, "first frame", {24'd0, tcmd[7:0]}, {24'd0, lo});
    recv_frame(tname, hi, idle);
    if (hi !== tcmd[15:8])
      report_mismatch(tname, "second frame", {24'd0, tcmd[15:8]}, {24'd0, hi});
    // The stop bit ends half a bit plus one cycle after its mid sample
    if (idle - BAUD_DIV / 2 - 1 < GAP_BITS * BAUD_DIV)
    begin
      $display("Case %0s: only %0d idle cycles between frames", tname, idle - BAUD_DIV / 2 - 1);
      other_errs = other_errs + 1;
    end
    if (!tcmd[CMD_RW_BIT] && tfault != 2)
    begin
      repeat (BAUD_DIV / 2 + (GAP_BITS + 1) * BAUD_DIV) @(negedge clk);  // Receiver armed by now
      extra = $unsigned($random(seed)) % 6;
      repeat (extra * BAUD_DIV) @(negedge clk);
      send_frame(tresp, tfault == 1);
    end
  endtask

  // ##########################################################
  // One transaction from the cases file
  // ##########################################################

  task automatic run_case(input logic [127:0] tname, input logic [15:0] tcmd,
                          input logic [7:0] tresp, input integer tfault,
                          input logic [7:0] trd);
    logic        err;
    logic [31:0] status;
    logic [31:0] exp_status;
    logic [31:0] rd;
    integer      t0;
    exp_status              = '0;
    exp_status[ST_DONE]     = 1'b1;
    exp_status[ST_PERR]     = !tcmd[CMD_RW_BIT] && (tfault == 1);
    exp_status[ST_TIMEOUT]  = !tcmd[CMD_RW_BIT] && (tfault == 2);
    status = '0;
    t0     = cycle_cnt;
    fork
      run_peer(tname, tcmd, tresp, tfault);
      begin
        apb_write(tname, ADDR_CMD, {16'd0, tcmd}, err);
        if (err !== 1'b0)
          report_mismatch(tname, "pslverr on launch", 32'd0, {31'd0, err});
        apb_write(tname, ADDR_CMD, {16'd0, ~tcmd}, err);  // Must be refused
        if (err !== 1'b1)
          report_mismatch(tname, "pslverr while busy", 32'd1, {31'd0, err});
        while (!status[ST_DONE] &&
               cycle_cnt - t0 < (2 * FRAME_BITS + 2 * GAP_BITS + RX_TIMEOUT_BITS + 8) * BAUD_DIV)
          apb_read(tname, ADDR_STATUS, status);
        if (!status[ST_DONE])
        begin
          $display("Case %0s: STATUS never showed done within the time bound", tname);
          other_errs = other_errs + 1;
        end
      end
    join
    if (status !== exp_status)
      report_mismatch(tname, "STATUS", exp_status, status);
    if (!tcmd[CMD_RW_BIT])
    begin
      apb_read(tname, ADDR_RDATA, rd);
      if (rd !== {24'd0, trd})
        report_mismatch(tname, "RDATA", {24'd0, trd}, rd);
    end
  endtask

  initial
  begin
    value_errs = 0;
    other_errs = 0;
    n_cases    = 0;
    cycle_cnt  = 0;
    seed       = 32'hb348a0d9;
    clk        = 1'b0;
    rst_n      = 1'b0;
    paddr      = '0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    pwdata     = '0;
    rx         = 1'b1;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    fd = $fopen("dv/uart_cmd_cases.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open dv/uart_cmd_cases.txt");
      other_errs = other_errs + 1;
    end
    else
    begin
      while ($fgets(line, fd) != 0)
      begin
        if (line.len() == 0 || line[0] == "#")
          continue;
        if ($sscanf(line, "%s %h %h %d %h", name, cmd, resp, fault, exp_rd) != 5)
          continue;
        run_case(name, cmd, resp, fault, exp_rd);
        n_cases = n_cases + 1;
      end
      $fclose(fd);
    end
    if (n_cases == 0)
    begin
      $display("No cases were read from the cases file");
      other_errs = other_errs + 1;
    end

    $display("Cases: %0d, value errors: %0d, other errors: %0d", n_cases, value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

// File: dv/uart_cmd_cases.txt
# name  cmd(hex)  peer response(hex)  fault(0 none, 1 bad parity, 2 silent)  rdata(hex)
# rdata is checked for reads only, bit 15 of cmd set means write
wr_basic     a55a  00  0  00
wr_ones      ffff  00  0  00
wr_hi_only   8000  00  0  00
rd_basic     1234  c3  0  c3
rd_zero      0000  00  0  00
rd_ones      7fff  ff  0  ff
rd_perr      0abc  5a  1  5a
rd_silent    0101  00  2  00
wr_after     9a0f  00  0  00
rd_last      7e81  96  0  96

// File: vlog.f
hw/uart_cmd_pkg.sv
hw/uart_rx_if.sv
hw/uart_tx_frame.sv
hw/uart_rx_frame.sv
hw/uart_cmd_seq.sv
hw/uart_cmd_apb.sv
hw/uart_cmd_top.sv
dv/uart_cmd_assert.sv
dv/uart_cmd_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= uart_cmd_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(OBJ_DIR)
